// ==== bench/elink_clkgen.sv ====
/*
 Testbench clock and reset source for the eLink block.
 40 ns clock, reset held low for the first 10 cycles.
*/
`timescale 1ns/1ps
`default_nettype none

module elink_clkgen (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk    = 1'b0;
      arst_n = 1'b0;                                // In reset from time 0
      repeat (10) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;                                // Release away from the active edge
   end

   always #20 clk = ~clk;                           // 40 ns period

endmodule

`default_nettype wire

// ==== bench/elink_tb.sv ====
/*
 Table driven testbench for the eLink host block. Rows of APB accesses,
 flag checks and frame waits run in order against the DUT, a collector
 captures link bytes, and a cycle counter guards against a hang.
*/
`timescale 1ns/1ps
`default_nettype none

module elink_tb;

   typedef enum logic [2:0] {OP_WR, OP_RD, OP_FLAGS, OP_FRAME, OP_STALL_FRAME, OP_NOFRAME} op_t;

   typedef struct packed {
      op_t                  kind;
      elink_pkg::apb_addr_t addr;
      elink_pkg::word_t     data;                   // Write data, or cycles for frame rows
      elink_pkg::word_t     exp_rd;
      logic                 exp_err;
      logic [71:0]          exp_frame;              // Header, address, data
   } row_t;

   localparam int WORST_FRAME = 2 * elink_pkg::FRAME_BEATS * 16;  // clkdiv 15 with stalls
   localparam int MARGIN      = 200;

   wire                 clk, arst_n;
   wire                 tx_frame, tx_lclk, embox_full, embox_not_empty;
   elink_pkg::apb_req_t apb;
   elink_pkg::apb_rsp_t apb_rsp;
   elink_pkg::byte_t    tx_data;
   logic                tx_wr_wait;

   row_t                table_q[$];
   elink_pkg::byte_t    got_bytes[$];               // Bytes seen on tx_lclk
   elink_pkg::word_t    rd_data;
   logic                rd_err;
   logic [31:0]         rnd;
   int                  frame_cycles = 0, cycles = 0, checks = 0, errors = 0;
   int                  stall_cycles = 0;           // Frame cycles under tx_wr_wait
   int                  timeout_limit;

   elink_clkgen u_clkgen (.clk, .arst_n);

   elink_top DUT (
      .clk, .arst_n, .apb, .apb_rsp, .tx_data, .tx_frame, .tx_lclk, .tx_wr_wait,
      .embox_full, .embox_not_empty);

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   task automatic compare(input logic [71:0] got, input logic [71:0] exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
      end
   endtask

   function automatic void add_row(op_t kind, elink_pkg::apb_addr_t addr,
                                   elink_pkg::word_t data, elink_pkg::word_t exp_rd,
                                   logic exp_err, logic [71:0] exp_frame);
      table_q.push_back('{kind, addr, data, exp_rd, exp_err, exp_frame});
   endfunction

   // Enters at a falling edge, leaves at the falling edge after the access phase
   task automatic apb_access(input logic write, input elink_pkg::apb_addr_t addr,
                             input elink_pkg::word_t data);
      apb = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: data};
      @(negedge clk);
      apb.penable = 1'b1;
      @(posedge clk);
      rd_data = apb_rsp.prdata;                     // Pre-edge access phase values
      rd_err  = apb_rsp.pslverr;
      compare(apb_rsp.pready, 1'b1, "pready in access phase");
      @(negedge clk);
      apb.psel    = 1'b0;
      apb.penable = 1'b0;
   endtask

   task automatic wait_frame(input logic stall);
      logic started;
      started = 1'b0;
      while (!started || tx_frame) begin
         if (tx_frame)
            started = 1'b1;
         if (stall) begin
            rnd        = xorshift(rnd);
            tx_wr_wait = rnd[0];                    // Random far end back-pressure
         end
         @(negedge clk);
      end
      tx_wr_wait = 1'b0;
   endtask

   task automatic run_row(input row_t row);
      logic [71:0] got_frame;
      got_frame = '0;
      case (row.kind)
         OP_WR: begin
            apb_access(1'b1, row.addr, row.data);
            compare(rd_err, row.exp_err, $sformatf("pslverr on write 0x%02h", row.addr));
         end
         OP_RD: begin
            apb_access(1'b0, row.addr, '0);
            compare(rd_data, row.exp_rd, $sformatf("read data at 0x%02h", row.addr));
            compare(rd_err, row.exp_err, $sformatf("pslverr on read 0x%02h", row.addr));
         end
         OP_FLAGS: compare({embox_full, embox_not_empty}, row.exp_rd, "mailbox flag pins");
         OP_FRAME, OP_STALL_FRAME: begin
            wait_frame(row.kind == OP_STALL_FRAME);
            foreach (got_bytes[i])
               got_frame = {got_frame[63:0], got_bytes[i]};
            compare(got_bytes.size(), elink_pkg::FRAME_BEATS, "bytes per frame");
            compare(got_frame, row.exp_frame, "frame bytes");
            if (row.data != 0)
               compare(frame_cycles, row.data + stall_cycles, "tx_frame length in cycles");
            got_bytes.delete();
            frame_cycles = 0;
            stall_cycles = 0;
         end
         default: begin                             // No frame may start
            repeat (row.data) @(negedge clk);
            compare(frame_cycles + got_bytes.size(), 0, "frame after refused launch");
         end
      endcase
   endtask

   task automatic fill_table();
      add_row(OP_FLAGS, 0, 0, 0, 0, 0);                                // Reset state
      add_row(OP_RD, elink_pkg::REG_STATUS, 0, 0, 0, 0);
      add_row(OP_WR, elink_pkg::REG_CFG, 32'hFFFF_F5A1, 0, 0, 0);
      add_row(OP_WR, elink_pkg::REG_COREID, 32'hFFFF_FABC, 0, 0, 0);
      add_row(OP_WR, elink_pkg::REG_TX_ADDR, 32'h1234_5678, 0, 0, 0);
      add_row(OP_RD, elink_pkg::REG_CFG, 0, 32'h0000_05A1, 0, 0);     // Fields only
      add_row(OP_RD, elink_pkg::REG_COREID, 0, 32'h0000_0ABC, 0, 0);
      add_row(OP_RD, elink_pkg::REG_TX_ADDR, 0, 32'h1234_5678, 0, 0);
      add_row(OP_RD, 8'h18, 0, 0, 1, 0);                               // Unmapped
      add_row(OP_WR, elink_pkg::REG_STATUS, 32'hFFFF_FFFF, 0, 1, 0);
      add_row(OP_RD, elink_pkg::REG_CFG, 0, 32'h0000_05A1, 0, 0);
      add_row(OP_RD, elink_pkg::REG_STATUS, 0, 0, 0, 0);
      for (int i = 0; i < elink_pkg::MBOX_DEPTH; i++)
         add_row(OP_WR, elink_pkg::REG_MBOX, 32'hA000_0000 + i * 32'h0101, 0, 0, 0);
      add_row(OP_WR, elink_pkg::REG_MBOX, 32'hDEAD_BEEF, 0, 1, 0);    // Ninth push
      add_row(OP_FLAGS, 0, 0, 2'b11, 0, 0);
      add_row(OP_RD, elink_pkg::REG_STATUS, 0, 32'h0000_0086, 0, 0);  // Count 8, full
      for (int i = 0; i < elink_pkg::MBOX_DEPTH; i++)
         add_row(OP_RD, elink_pkg::REG_MBOX, 0, 32'hA000_0000 + i * 32'h0101, 0, 0);
      add_row(OP_RD, elink_pkg::REG_MBOX, 0, 0, 1, 0);                 // Pop when empty
      add_row(OP_FLAGS, 0, 0, 2'b00, 0, 0);
      add_row(OP_WR, elink_pkg::REG_CFG, 32'h0000_0501, 0, 0, 0);     // clkdiv 0
      add_row(OP_WR, elink_pkg::REG_TX_DATA, 32'hCAFE_F00D, 0, 0, 0);
      add_row(OP_FRAME, 0, 9, 0, 0, {8'h51, 32'h1234_5678, 32'hCAFE_F00D});
      add_row(OP_WR, elink_pkg::REG_CFG, 32'h0000_0531, 0, 0, 0);     // clkdiv 3
      add_row(OP_WR, elink_pkg::REG_TX_DATA, 32'h0102_0304, 0, 0, 0);
      add_row(OP_FRAME, 0, 36, 0, 0, {8'h51, 32'h1234_5678, 32'h0102_0304});
      add_row(OP_WR, elink_pkg::REG_TX_ADDR, 32'h000A_BCDE, 0, 0, 0); // Local address
      add_row(OP_WR, elink_pkg::REG_TX_DATA, 32'h55AA_55AA, 0, 0, 0);
      add_row(OP_FRAME, 0, 36, 0, 0, {8'h51, 32'hABCA_BCDE, 32'h55AA_55AA});
      add_row(OP_WR, elink_pkg::REG_TX_DATA, 32'h55AA_55AA, 0, 0, 0);
      add_row(OP_STALL_FRAME, 0, 36, 0, 0, {8'h51, 32'hABCA_BCDE, 32'h55AA_55AA});
      add_row(OP_WR, elink_pkg::REG_TX_DATA, 32'h1111_1111, 0, 0, 0);
      add_row(OP_RD, elink_pkg::REG_STATUS, 0, 32'h0000_0001, 0, 0);  // Busy mid frame
      add_row(OP_WR, elink_pkg::REG_TX_DATA, 32'h2222_2222, 0, 1, 0); // While busy
      add_row(OP_FRAME, 0, 36, 0, 0, {8'h51, 32'hABCA_BCDE, 32'h1111_1111});
      add_row(OP_NOFRAME, 0, 40, 0, 0, 0);
      add_row(OP_RD, elink_pkg::REG_TX_DATA, 0, 32'h1111_1111, 0, 0);
      add_row(OP_WR, elink_pkg::REG_CFG, 32'h0000_0530, 0, 0, 0);     // tx_enable low
      add_row(OP_WR, elink_pkg::REG_TX_DATA, 32'h3333_3333, 0, 1, 0);
      add_row(OP_NOFRAME, 0, 40, 0, 0, 0);
   endtask

   // Link collector samples on the rising edge before the DUT updates
   always @(posedge clk) begin
      if (tx_frame)
         frame_cycles++;
      if (tx_frame && tx_wr_wait)
         stall_cycles++;                            // Each stalled cycle stretches the frame
      if (tx_frame && tx_lclk)
         got_bytes.push_back(tx_data);
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > timeout_limit) begin
         $display("timeout: the run did not finish within %0d cycles", timeout_limit);
         $display("Finished with errors");
         $finish;
      end
   end

   initial begin
      apb        = '0;
      tx_wr_wait = 1'b0;
      rnd        = 32'he498;
      fill_table();
      timeout_limit = table_q.size() * WORST_FRAME + MARGIN;
      @(posedge arst_n);
      @(negedge clk);
      foreach (table_q[n])
         run_row(table_q[n]);
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

// ==== elink_top.f ====
logic/elink_pkg.sv
logic/elink_regs.sv
logic/elink_mailbox.sv
logic/elink_tx_fsm.sv
logic/elink_tx_beat_timer.sv
logic/elink_tx_shifter.sv
logic/elink_top.sv
bench/elink_clkgen.sv
bench/elink_tb.sv

// ==== logic/elink_mailbox.sv ====
/*
 General purpose mailbox built as an 8 entry circular FIFO.
 The head word is always visible on rdata for a same-cycle pop.
 Callers guarantee no push when full and no pop when empty.
*/
`timescale 1ns/1ps
`default_nettype none

module elink_mailbox (
   input  wire                      clk,
   input  wire                      arst_n,
   input  wire                      push,
   input  wire                      pop,
   input  elink_pkg::word_t         wdata,
   output elink_pkg::word_t         rdata,
   output elink_pkg::mbox_count_t   count,
   output logic                     full,
   output logic                     not_empty
);

   localparam int PTR_W = $clog2(elink_pkg::MBOX_DEPTH);

   elink_pkg::word_t mem [elink_pkg::MBOX_DEPTH];   // Word storage
   logic [PTR_W-1:0] wr_ptr, rd_ptr;                // Wrap naturally at depth 8

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= wdata;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;                // Both or neither
         endcase
      end
   end

   assign rdata     = mem[rd_ptr];                  // Head of queue
   assign full      = (count == elink_pkg::mbox_count_t'(elink_pkg::MBOX_DEPTH));
   assign not_empty = (count != '0);

endmodule

`default_nettype wire

// ==== logic/elink_pkg.sv ====
/*
 Shared types and constants for the reduced eLink host block.
 Holds the register map, the frame layout and the APB and transmit
 structs used by the RTL and the testbench.
*/
`default_nettype none

package elink_pkg;

   typedef logic [7:0]  apb_addr_t;                // APB byte address
   typedef logic [31:0] word_t;                    // Register and payload word
   typedef logic [7:0]  byte_t;                    // One link beat
   typedef logic [3:0]  clkdiv_t;                  // Beat is clkdiv+1 cycles
   typedef logic [3:0]  ctrl_mode_t;               // Header upper nibble
   typedef logic [11:0] coreid_t;                  // Mesh core id
   typedef logic [3:0]  mbox_count_t;              // 0 to 8 entries
   typedef logic [3:0]  beat_t;                    // Beat index 0 to 8

   localparam int         MBOX_DEPTH   = 8;
   localparam int         FRAME_BEATS  = 9;        // Header, 4 addr, 4 data
   localparam logic [3:0] WRITE_OPCODE = 4'h1;

   // Register map
   localparam apb_addr_t REG_CFG     = 8'h00;
   localparam apb_addr_t REG_COREID  = 8'h04;
   localparam apb_addr_t REG_TX_ADDR = 8'h08;
   localparam apb_addr_t REG_TX_DATA = 8'h0C;      // Write launches a frame
   localparam apb_addr_t REG_STATUS  = 8'h10;      // Read only
   localparam apb_addr_t REG_MBOX    = 8'h14;      // Write push, read pop

   typedef struct packed {
      logic      psel;
      logic      penable;
      logic      pwrite;
      apb_addr_t paddr;
      word_t     pwdata;
   } apb_req_t;

   typedef struct packed {
      word_t prdata;
      logic  pready;
      logic  pslverr;
   } apb_rsp_t;

   typedef struct packed {
      logic       tx_enable;
      clkdiv_t    clkdiv;
      ctrl_mode_t ctrl_mode;
      coreid_t    coreid;
   } cfg_t;

   typedef struct packed {
      word_t      addr;                            // Staged address
      word_t      data;                            // Word from the launching write
      ctrl_mode_t ctrl_mode;
      coreid_t    coreid;
   } tx_req_t;

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_LOAD,
      TX_SEND
   } tx_state_t;

endpackage

`default_nettype wire

// ==== logic/elink_regs.sv ====
/*
 APB configuration slave. Holds the config and staging registers,
 decides the slave errors, steers the mailbox and fires the launch
 pulse for the transmitter. pready is tied high for zero wait states.
*/
`timescale 1ns/1ps
`default_nettype none

module elink_regs (
   input  wire                      clk,
   input  wire                      arst_n,
   input  elink_pkg::apb_req_t      apb,
   output elink_pkg::apb_rsp_t      apb_rsp,
   output elink_pkg::cfg_t          cfg,
   output elink_pkg::tx_req_t       req,
   output logic                     launch,
   output logic                     push,
   output logic                     pop,
   output elink_pkg::word_t         wdata,
   input  wire                      busy,
   input  elink_pkg::word_t         mbox_rdata,
   input  elink_pkg::mbox_count_t   mbox_count,
   input  wire                      mbox_full,
   input  wire                      mbox_not_empty
);

   logic             access, wr, rd;
   logic             addr_ok, slv_err, wr_ok;
   elink_pkg::word_t rd_word;
   elink_pkg::word_t tx_addr_q, tx_data_q;

   assign access = apb.psel & apb.penable;          // Access phase only
   assign wr     = access & apb.pwrite;
   assign rd     = access & ~apb.pwrite;

   always_comb begin
      rd_word = '0;
      addr_ok = 1'b1;
      case (apb.paddr)
         elink_pkg::REG_CFG:     rd_word = {20'd0, cfg.ctrl_mode, cfg.clkdiv, 3'd0, cfg.tx_enable};
         elink_pkg::REG_COREID:  rd_word = {20'd0, cfg.coreid};
         elink_pkg::REG_TX_ADDR: rd_word = tx_addr_q;
         elink_pkg::REG_TX_DATA: rd_word = tx_data_q;
         elink_pkg::REG_STATUS:  rd_word = {24'd0, mbox_count, 1'b0, mbox_full,
                                            mbox_not_empty, busy};
         elink_pkg::REG_MBOX:    rd_word = mbox_not_empty ? mbox_rdata : '0; // Empty pop reads 0
         default:                addr_ok = 1'b0;    // Unmapped or misaligned
      endcase
   end

   assign slv_err = !addr_ok
                 || (wr && apb.paddr == elink_pkg::REG_STATUS)
                 || (wr && apb.paddr == elink_pkg::REG_MBOX && mbox_full)
                 || (rd && apb.paddr == elink_pkg::REG_MBOX && !mbox_not_empty)
                 || (wr && apb.paddr == elink_pkg::REG_TX_DATA
                        && (busy || !cfg.tx_enable));           // Refused launch

   assign wr_ok  = wr & ~slv_err;                   // Erroring writes change nothing
   assign launch = wr_ok & (apb.paddr == elink_pkg::REG_TX_DATA);
   assign push   = wr_ok & (apb.paddr == elink_pkg::REG_MBOX);
   assign pop    = rd & ~slv_err & (apb.paddr == elink_pkg::REG_MBOX);
   assign wdata  = apb.pwdata;

   assign apb_rsp.prdata  = rd ? rd_word : '0;
   assign apb_rsp.pready  = 1'b1;
   assign apb_rsp.pslverr = access & slv_err;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cfg       <= '0;
         tx_addr_q <= '0;
         tx_data_q <= '0;
      end else if (wr_ok) begin
         case (apb.paddr)
            elink_pkg::REG_CFG: begin
               cfg.tx_enable <= apb.pwdata[0];
               cfg.clkdiv    <= apb.pwdata[7:4];
               cfg.ctrl_mode <= apb.pwdata[11:8];
            end
            elink_pkg::REG_COREID:  cfg.coreid <= apb.pwdata[11:0];
            elink_pkg::REG_TX_ADDR: tx_addr_q  <= apb.pwdata;
            elink_pkg::REG_TX_DATA: tx_data_q  <= apb.pwdata;
            default: ;                              // Mailbox push handled by FIFO
         endcase
      end
   end

   // Snapshot for the shifter, stable from TX_LOAD on
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         req <= '0;
      end else if (launch) begin
         req.addr      <= tx_addr_q;
         req.data      <= apb.pwdata;               // Same word as the launching write
         req.ctrl_mode <= cfg.ctrl_mode;
         req.coreid    <= cfg.coreid;
      end
   end

endmodule

`default_nettype wire

// ==== logic/elink_top.sv ====
/*
 Top of the reduced eLink host block. Ties the APB register slave,
 the mailbox and the three transmit blocks together. tx_lclk is the
 beat strobe, seen only while a frame is being sent.
*/
`timescale 1ns/1ps
`default_nettype none

module elink_top (
   input  wire                  clk,
   input  wire                  arst_n,
   input  elink_pkg::apb_req_t  apb,
   output elink_pkg::apb_rsp_t  apb_rsp,
   output elink_pkg::byte_t     tx_data,
   output logic                 tx_frame,
   output logic                 tx_lclk,
   input  wire                  tx_wr_wait,
   output logic                 embox_full,
   output logic                 embox_not_empty
);

   elink_pkg::cfg_t          cfg;
   elink_pkg::tx_req_t       req;
   elink_pkg::word_t         wdata, mbox_rdata;
   elink_pkg::mbox_count_t   mbox_count;
   logic                     launch, busy, push, pop;
   logic                     load, run, beat_end, last_beat;

   elink_regs u_regs (
      .clk, .arst_n, .apb, .apb_rsp, .cfg, .req, .launch, .push, .pop, .wdata, .busy,
      .mbox_rdata, .mbox_count, .mbox_full(embox_full), .mbox_not_empty(embox_not_empty));

   elink_mailbox u_mailbox (
      .clk, .arst_n, .push, .pop, .wdata, .rdata(mbox_rdata), .count(mbox_count),
      .full(embox_full), .not_empty(embox_not_empty));

   elink_tx_fsm u_tx_fsm (
      .clk, .arst_n, .launch, .beat_end, .last_beat, .load, .run, .tx_frame, .busy);

   elink_tx_beat_timer u_tx_beat_timer (
      .clk, .arst_n, .run, .tx_wr_wait, .clkdiv(cfg.clkdiv), .beat_end, .last_beat);

   elink_tx_shifter u_tx_shifter (
      .clk, .arst_n, .load, .shift(beat_end), .req, .tx_data);

   assign tx_lclk = beat_end & run;                 // Quiet outside a frame

endmodule

`default_nettype wire

// ==== logic/elink_tx_beat_timer.sv ====
/*
 Beat timer for the transmit link. Divides clk by clkdiv+1 to pace
 the beats and counts them, freezing while the far end asserts
 tx_wr_wait. Both counters sit at zero outside a frame.
*/
`timescale 1ns/1ps
`default_nettype none

module elink_tx_beat_timer (
   input  wire                 clk,
   input  wire                 arst_n,
   input  wire                 run,
   input  wire                 tx_wr_wait,
   input  elink_pkg::clkdiv_t  clkdiv,
   output logic                beat_end,
   output logic                last_beat
);

   elink_pkg::clkdiv_t div_cnt;                     // Cycle within beat
   elink_pkg::beat_t   beat_idx;                    // Beat within frame

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         div_cnt  <= '0;
         beat_idx <= '0;
      end else if (!run) begin
         div_cnt  <= '0;                            // Ready for the next frame
         beat_idx <= '0;
      end else if (beat_end) begin
         div_cnt  <= '0;
         beat_idx <= beat_idx + 1'b1;
      end else if (!tx_wr_wait) begin
         div_cnt  <= div_cnt + 1'b1;                // Holds under back-pressure
      end
   end

   assign beat_end  = ~tx_wr_wait & (div_cnt == clkdiv);  // Final cycle of a beat
   assign last_beat = (beat_idx == elink_pkg::beat_t'(elink_pkg::FRAME_BEATS - 1));

endmodule

`default_nettype wire

// ==== logic/elink_tx_fsm.sv ====
/*
 Transmit sequencer. A launch pulse moves it through one load cycle
 into the send state, where it holds tx_frame until the beat timer
 reports the end of the ninth beat.
*/
`timescale 1ns/1ps
`default_nettype none

module elink_tx_fsm (
   input  wire  clk,
   input  wire  arst_n,
   input  wire  launch,
   input  wire  beat_end,
   input  wire  last_beat,
   output logic load,
   output logic run,
   output logic tx_frame,
   output logic busy
);

   elink_pkg::tx_state_t state, state_nxt;

   always_comb begin
      state_nxt = state;
      case (state)
         elink_pkg::TX_IDLE: if (launch) state_nxt = elink_pkg::TX_LOAD;
         elink_pkg::TX_LOAD: state_nxt = elink_pkg::TX_SEND;  // Single cycle
         elink_pkg::TX_SEND: if (beat_end && last_beat) state_nxt = elink_pkg::TX_IDLE;
         default:            state_nxt = elink_pkg::TX_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= elink_pkg::TX_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   assign load     = (state == elink_pkg::TX_LOAD);     // Shifter builds frame
   assign run      = (state == elink_pkg::TX_SEND);     // Timer counts
   assign tx_frame = (state == elink_pkg::TX_SEND);
   assign busy     = (state != elink_pkg::TX_IDLE);

endmodule

`default_nettype wire

// ==== logic/elink_tx_shifter.sv ====
/*
 Frame builder and byte serializer. On load it packs header, address
 and data into a 9 byte shift register, most significant byte first,
 and each shift moves the next byte onto tx_data.
*/
`timescale 1ns/1ps
`default_nettype none

module elink_tx_shifter (
   input  wire                 clk,
   input  wire                 arst_n,
   input  wire                 load,
   input  wire                 shift,
   input  elink_pkg::tx_req_t  req,
   output elink_pkg::byte_t    tx_data
);

   elink_pkg::byte_t [elink_pkg::FRAME_BEATS-1:0] frame;   // Top byte goes out first
   elink_pkg::word_t                              frame_addr;
   elink_pkg::byte_t                              header;

   // Low addresses are local, so the core id fills the top 12 bits
   assign frame_addr = (req.addr[31:20] == '0) ? {req.coreid, req.addr[19:0]}
                                               : req.addr;
   assign header     = {req.ctrl_mode, elink_pkg::WRITE_OPCODE};

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         frame <= '0;
      end else if (load) begin
         frame <= {header, frame_addr, req.data};           // Load wins over shift
      end else if (shift) begin
         frame <= {frame[elink_pkg::FRAME_BEATS-2:0], 8'h00};
      end
   end

   assign tx_data = frame[elink_pkg::FRAME_BEATS-1];

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Compile the eLink testbench with Verilator, run it, and decide pass or fail from the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module elink_tb \
   -f elink_top.f -o elink_sim

./obj_dir/elink_sim | tee sim.log

# The testbench prints this exact line only when every check passed
grep -qx "Finished with no errors" sim.log
